// File: rtl/mcsr_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types and constants of the machine-mode CSR unit.
// Addresses follow the standard RISC-V numbering. Only M-mode exists.
//////////////////////////////////////////////////////////////////////
package mcsr_pkg;

    // Register width.
    localparam int xlen = 32;
    // Lowest external interrupt number.
    localparam int irq_first = 16;

    // CSR addresses.
    localparam logic [11:0] csr_mstatus    = 12'h300;
    localparam logic [11:0] csr_misa       = 12'h301;
    localparam logic [11:0] csr_medeleg    = 12'h302;
    localparam logic [11:0] csr_mideleg    = 12'h303;
    localparam logic [11:0] csr_mie        = 12'h304;
    localparam logic [11:0] csr_mtvec      = 12'h305;
    localparam logic [11:0] csr_mstatush   = 12'h310;
    localparam logic [11:0] csr_mscratch   = 12'h340;
    localparam logic [11:0] csr_mepc       = 12'h341;
    localparam logic [11:0] csr_mcause     = 12'h342;
    localparam logic [11:0] csr_mtval      = 12'h343;
    localparam logic [11:0] csr_mip        = 12'h344;
    localparam logic [11:0] csr_mvendorid  = 12'hf11;
    localparam logic [11:0] csr_marchid    = 12'hf12;
    localparam logic [11:0] csr_mimpid     = 12'hf13;
    localparam logic [11:0] csr_mhartid    = 12'hf14;
    localparam logic [11:0] csr_mconfigptr = 12'hf15;

    // RV32IM: MXL=1, extensions I and M.
    localparam logic [xlen-1:0] misa_value = 32'h4000_1100;

    // One select per implemented CSR.
    typedef enum logic [4:0] {
        sel_none,
        sel_mstatus,
        sel_misa,
        sel_medeleg,
        sel_mideleg,
        sel_mie,
        sel_mtvec,
        sel_mstatush,
        sel_mip,
        sel_mscratch,
        sel_mepc,
        sel_mcause,
        sel_mtval,
        sel_mvendorid,
        sel_marchid,
        sel_mimpid,
        sel_mhartid,
        sel_mconfigptr
    } csr_sel_e;

    // CSR access from the core.
    typedef struct packed {
        logic            we;
        logic [11:0]     addr;
        logic [xlen-1:0] wdata;
    } csr_req_t;

    // CSR access result, same cycle.
    typedef struct packed {
        logic            exists;
        logic            rdonly;
        logic [xlen-1:0] rdata;
    } csr_rsp_t;

    // Synchronous trap reported by the core.
    typedef struct packed {
        logic        valid;
        logic [3:0]  cause;
        logic [31:1] epc;
    } trap_req_t;

    typedef struct packed {
        logic       pending;
        logic [4:0] cause;
    } irq_req_t;

    // Kind of register update in a cycle.
    typedef enum logic [1:0] {
        upd_none,
        upd_ret,
        upd_enter,
        upd_write
    } upd_e;

    typedef struct packed {
        upd_e        kind;
        logic        is_irq;
        logic [4:0]  cause;
        logic [31:1] epc;
    } upd_t;

    // Exception dispatch towards the core.
    typedef struct packed {
        logic        take;
        logic        is_irq;
        logic [31:2] tvec;
        logic [31:1] ret_epc;
    } exc_out_t;

endpackage

// File: rtl/csr_addr_decode.sv
//////////////////////////////////////////////////////////////////////
// Combinational CSR address decode. Unknown addresses give sel_none.
//////////////////////////////////////////////////////////////////////
module csr_addr_decode (
    input  logic [11:0]        addr,
    output mcsr_pkg::csr_sel_e sel,
    output logic               exists,
    output logic               rdonly
);
    import mcsr_pkg::*;

    always_comb begin
        // Defaults for an unknown address.
        sel    = sel_none;
        exists = 1'b1;
        rdonly = 1'b0;
        case (addr)
            csr_mstatus:    sel = sel_mstatus;
            csr_misa:       sel = sel_misa;
            csr_medeleg:    sel = sel_medeleg;
            csr_mideleg:    sel = sel_mideleg;
            csr_mie:        sel = sel_mie;
            csr_mtvec:      sel = sel_mtvec;
            csr_mstatush:   sel = sel_mstatush;
            csr_mip:        sel = sel_mip;
            csr_mscratch:   sel = sel_mscratch;
            csr_mepc:       sel = sel_mepc;
            csr_mcause:     sel = sel_mcause;
            csr_mtval:      sel = sel_mtval;
            // Identity block, read-only.
            csr_mvendorid: begin
                sel    = sel_mvendorid;
                rdonly = 1'b1;
            end
            csr_marchid: begin
                sel    = sel_marchid;
                rdonly = 1'b1;
            end
            csr_mimpid: begin
                sel    = sel_mimpid;
                rdonly = 1'b1;
            end
            csr_mhartid: begin
                sel    = sel_mhartid;
                rdonly = 1'b1;
            end
            csr_mconfigptr: begin
                sel    = sel_mconfigptr;
                rdonly = 1'b1;
            end
            default:        exists = 1'b0;
        endcase
    end

endmodule

// File: rtl/irq_arbiter.sv
//////////////////////////////////////////////////////////////////////
// External interrupt sampling and priority. Lines are registered once,
// so a request shows one cycle after the line rises. Lowest wins.
//////////////////////////////////////////////////////////////////////
module irq_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic [31:16]       irq,
    input  logic [31:0]        mie,
    input  logic               mstatus_mie,
    output logic [31:0]        ip,
    output mcsr_pkg::irq_req_t irq_req
);
    import mcsr_pkg::*;

    // MIE as seen in the previous cycle.
    logic            prev_mie;
    // Pending and enabled.
    logic [xlen-1:0] masked;

    always_ff @(posedge clk) begin
        if (rst) begin
            ip       <= '0;
            prev_mie <= 1'b0;
        end else begin
            // Internal interrupt numbers stay 0.
            ip       <= {irq, {irq_first{1'b0}}};
            prev_mie <= mstatus_mie;
        end
    end

    assign masked = ip & mie;

    always_comb begin
        irq_req.cause = 5'd0;
        // Scan downward, the last hit is the lowest number.
        for (int i = xlen - 1; i >= irq_first; i--) begin
            if (masked[i]) begin
                irq_req.cause = 5'(i);
            end
        end
        // MIE must have been set for two cycles in a row.
        irq_req.pending = (masked != '0) && mstatus_mie && prev_mie;
    end

endmodule

// File: rtl/trap_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Picks the one CSR update of the cycle. Priority is mret, interrupt,
// trap, then CSR write. Writes to read-only or missing CSRs are lost.
//////////////////////////////////////////////////////////////////////
module trap_ctrl (
    input  mcsr_pkg::csr_req_t  csr_req,
    input  logic                exists,
    input  logic                rdonly,
    input  mcsr_pkg::trap_req_t trap,
    input  logic                mret,
    input  logic [31:1]         pc,
    input  mcsr_pkg::irq_req_t  irq_req,
    input  logic [31:2]         mtvec,
    input  logic [31:1]         mepc,
    output mcsr_pkg::upd_t      upd,
    output mcsr_pkg::exc_out_t  exc
);
    import mcsr_pkg::*;

    always_comb begin
        upd.kind   = upd_none;
        upd.is_irq = 1'b0;
        upd.cause  = 5'd0;
        upd.epc    = '0;
        if (mret) begin
            upd.kind = upd_ret;
        end else if (irq_req.pending) begin
            // Interrupt takes the current pc as return point.
            upd.kind   = upd_enter;
            upd.is_irq = 1'b1;
            upd.cause  = irq_req.cause;
            upd.epc    = pc;
        end else if (trap.valid) begin
            upd.kind  = upd_enter;
            upd.cause = {1'b0, trap.cause};
            upd.epc   = trap.epc;
        end else if (csr_req.we && exists && !rdonly) begin
            upd.kind = upd_write;
        end
    end

    // Dispatch only on trap entry.
    assign exc.take    = (upd.kind == upd_enter);
    assign exc.is_irq  = exc.take && upd.is_irq;
    // Vector and return address straight from the CSRs.
    assign exc.tvec    = mtvec;
    assign exc.ret_epc = mepc;

endmodule

// File: rtl/csr_regs.sv
//////////////////////////////////////////////////////////////////////
// CSR state, update and read mux. mtvec is direct mode only.
// mcause keeps the interrupt flag and a 5-bit number.
//////////////////////////////////////////////////////////////////////
module csr_regs #(
    parameter logic [31:0] hart_id = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst,
    input  mcsr_pkg::csr_sel_e sel,
    input  logic [31:0]        wdata,
    input  mcsr_pkg::upd_t     upd,
    input  logic [31:0]        ip,
    output logic [31:0]        rdata,
    output logic [31:0]        mie,
    output logic               mstatus_mie,
    output logic [31:2]        mtvec,
    output logic [31:1]        mepc
);
    import mcsr_pkg::*;

    // mstatus.MPIE.
    logic            mstatus_mpie;
    logic [xlen-1:0] mscratch;
    // mcause interrupt flag.
    logic            mcause_int;
    // mcause number.
    logic [4:0]      mcause_no;

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause_int   <= 1'b0;
            mcause_no    <= 5'd0;
        end else begin
            case (upd.kind)
                upd_ret: begin
                    // Return from trap.
                    mstatus_mie <= mstatus_mpie;
                end
                upd_enter: begin
                    mstatus_mpie <= mstatus_mie;
                    mstatus_mie  <= 1'b0;
                    mepc         <= upd.epc;
                    mcause_int   <= upd.is_irq;
                    mcause_no    <= upd.cause;
                end
                upd_write: begin
                    case (sel)
                        sel_mstatus: begin
                            mstatus_mpie <= wdata[7];
                            mstatus_mie  <= wdata[3];
                        end
                        sel_mie:      mie      <= wdata;
                        sel_mtvec:    mtvec    <= wdata[31:2];
                        sel_mscratch: mscratch <= wdata;
                        sel_mepc:     mepc     <= wdata[31:1];
                        sel_mcause: begin
                            mcause_int <= wdata[31];
                            mcause_no  <= wdata[4:0];
                        end
                        // Constant registers ignore writes.
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (sel)
            sel_mstatus:  rdata = {24'd0, mstatus_mpie, 3'd0, mstatus_mie, 3'd0};
            sel_misa:     rdata = misa_value;
            sel_mie:      rdata = mie;
            sel_mtvec:    rdata = {mtvec, 2'b00};
            // Only enabled lines show as pending.
            sel_mip:      rdata = ip & mie;
            sel_mscratch: rdata = mscratch;
            sel_mepc:     rdata = {mepc, 1'b0};
            sel_mcause:   rdata = {mcause_int, 26'd0, mcause_no};
            sel_mhartid:  rdata = hart_id;
            // Zero registers and no select.
            default:      rdata = '0;
        endcase
    end

endmodule

// File: rtl/mcsr_unit.sv
//////////////////////////////////////////////////////////////////////
// Machine-mode CSR unit. Requests are single-cycle strobes with no
// handshake. hart_id sets mhartid.
//////////////////////////////////////////////////////////////////////
module mcsr_unit #(
    parameter logic [31:0] hart_id = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                rst,
    input  mcsr_pkg::csr_req_t  csr_req,
    output mcsr_pkg::csr_rsp_t  csr_rsp,
    input  mcsr_pkg::trap_req_t trap,
    input  logic                mret,
    input  logic [31:1]         pc,
    input  logic [31:16]        irq,
    output mcsr_pkg::exc_out_t  exc
);
    import mcsr_pkg::*;

    // Decode results.
    csr_sel_e        sel;
    logic            exists;
    logic            rdonly;
    logic [xlen-1:0] rdata;
    // Interrupt path.
    irq_req_t        irq_req;
    logic [xlen-1:0] ip;
    // Update of the cycle.
    upd_t            upd;
    // CSR state fed back.
    logic [xlen-1:0] mie;
    logic            mstatus_mie;
    logic [31:2]     mtvec;
    logic [31:1]     mepc;

    assign csr_rsp.exists = exists;
    assign csr_rsp.rdonly = rdonly;
    assign csr_rsp.rdata  = rdata;

    csr_addr_decode i_decode (
        .addr   (csr_req.addr),
        .sel    (sel),
        .exists (exists),
        .rdonly (rdonly)
    );

    irq_arbiter i_irq (
        .clk         (clk),
        .rst         (rst),
        .irq         (irq),
        .mie         (mie),
        .mstatus_mie (mstatus_mie),
        .ip          (ip),
        .irq_req     (irq_req)
    );

    trap_ctrl i_ctrl (
        .csr_req (csr_req),
        .exists  (exists),
        .rdonly  (rdonly),
        .trap    (trap),
        .mret    (mret),
        .pc      (pc),
        .irq_req (irq_req),
        .mtvec   (mtvec),
        .mepc    (mepc),
        .upd     (upd),
        .exc     (exc)
    );

    csr_regs #(
        .hart_id (hart_id)
    ) i_regs (
        .clk         (clk),
        .rst         (rst),
        .sel         (sel),
        .wdata       (csr_req.wdata),
        .upd         (upd),
        .ip          (ip),
        .rdata       (rdata),
        .mie         (mie),
        .mstatus_mie (mstatus_mie),
        .mtvec       (mtvec),
        .mepc        (mepc)
    );

endmodule

// File: dv/mcsr_sva.sv
//////////////////////////////////////////////////////////////////////
// Protocol assertions for mcsr_unit, attached by bind.
// Reads the internal update and mstatus.MIE of the unit.
//////////////////////////////////////////////////////////////////////
module mcsr_sva (
    input logic                clk,
    input logic                rst,
    input logic                mret,
    input mcsr_pkg::exc_out_t  exc,
    input mcsr_pkg::upd_t      upd,
    input logic                mstatus_mie
);
    import mcsr_pkg::*;

    // No dispatch while in reset or in the first cycle after it.
    a_no_take_reset: assert property (@(posedge clk)
        (rst || $past(rst)) |-> (exc.take !== 1'b1))
        else $error("exception taken during or right after reset");

    // Trap entry always leaves interrupts disabled.
    a_enter_clears_mie: assert property (@(posedge clk) disable iff (rst)
        (upd.kind == upd_enter) |=> !mstatus_mie)
        else $error("mstatus.MIE still set after trap entry");

    // mret has the highest priority.
    a_take_not_mret: assert property (@(posedge clk) disable iff (rst)
        !(exc.take && mret))
        else $error("exception taken in the same cycle as mret");

endmodule

bind mcsr_unit mcsr_sva i_sva (
    .clk         (clk),
    .rst         (rst),
    .mret        (mret),
    .exc         (exc),
    .upd         (upd),
    .mstatus_mie (mstatus_mie)
);

// File: dv/mcsr_tb.sv
//////////////////////////////////////////////////////////////////////
// Random testbench for mcsr_unit with a cycle-level model.
// Inputs change on the falling edge; outputs are checked 10 units
// before the rising edge. The LCG seed is fixed.
//////////////////////////////////////////////////////////////////////
module mcsr_tb;
    import mcsr_pkg::*;

    localparam logic [31:0] hart_id = 32'h0000_0003;
    localparam int period = 100;
    // Iterations per test and cycles per iteration.
    localparam int n_unknown = 8;
    localparam int n_write   = 150;
    localparam int n_trap    = 50;
    localparam int n_irq     = 60;
    localparam int n_mret    = 60;
    localparam int n_mixed   = 2000;
    localparam int n_total   = 9 + 17 + n_unknown + 2 * n_write + 5 * n_trap
                               + 6 * n_irq + 5 * n_mret + n_mixed;
    localparam int margin    = 200;

    localparam logic [11:0] known_addr [17] = '{
        csr_mstatus, csr_misa, csr_medeleg, csr_mideleg, csr_mie, csr_mtvec,
        csr_mstatush, csr_mip, csr_mscratch, csr_mepc, csr_mcause, csr_mtval,
        csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid, csr_mconfigptr
    };

    logic         clk;
    logic         rst;
    csr_req_t     csr_req;
    csr_rsp_t     csr_rsp;
    trap_req_t    trap;
    logic         mret;
    logic [31:1]  pc;
    logic [31:16] irq;
    exc_out_t     exc;

    // Model of the CSR state.
    logic         m_mie_bit;
    logic         m_mpie;
    logic [31:0]  m_mie;
    logic [31:2]  m_mtvec;
    logic [31:0]  m_mscratch;
    logic [31:1]  m_mepc;
    logic         m_cause_int;
    logic [4:0]   m_cause_no;
    // Sampled lines and MIE of the cycle before.
    logic [31:16] m_ip;
    logic         m_prev_mie;

    logic [31:0]  lcg_state;
    int           test_cycles;
    int           test_errors;
    int           total_errors;
    int           checks;
    int           n_tests;

    mcsr_unit #(
        .hart_id (hart_id)
    ) i_dut (
        .clk     (clk),
        .rst     (rst),
        .csr_req (csr_req),
        .csr_rsp (csr_rsp),
        .trap    (trap),
        .mret    (mret),
        .pc      (pc),
        .irq     (irq),
        .exc     (exc)
    );

    always #(period / 2) clk = ~clk;

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Addresses 0x0xx and 0x7xx hold no CSR here.
    function automatic logic [11:0] unknown_addr(input logic [31:0] r);
        return {r[8] ? 4'h0 : 4'h7, r[7:0]};
    endfunction

    function automatic logic [11:0] pick_addr(input logic [31:0] r);
        if (r[3:0] == 4'h0) begin
            return unknown_addr(r);
        end
        return known_addr[int'(r[8:4]) % 17];
    endfunction

    function automatic csr_req_t make_req(input logic we, input logic [11:0] addr,
                                          input logic [31:0] wdata);
        csr_req_t q;
        q.we    = we;
        q.addr  = addr;
        q.wdata = wdata;
        return q;
    endfunction

    // Random cause and epc, valid as given.
    function automatic trap_req_t make_trap(input logic valid);
        trap_req_t   t;
        logic [31:0] r;
        r       = rand32();
        t.valid = valid;
        t.cause = r[3:0];
        r       = rand32();
        t.epc   = r[31:1];
        return t;
    endfunction

    // Expected read response from the model state.
    function automatic csr_rsp_t model_rsp(input logic [11:0] addr);
        csr_rsp_t r;
        r.exists = 1'b1;
        r.rdonly = 1'b0;
        r.rdata  = 32'd0;
        case (addr)
            csr_mstatus:  r.rdata = (32'(m_mpie) << 7) | (32'(m_mie_bit) << 3);
            // MXL 1 with I and M.
            csr_misa:     r.rdata = 32'h4000_1100;
            csr_mie:      r.rdata = m_mie;
            csr_mtvec:    r.rdata = {m_mtvec, 2'b00};
            csr_mip:      r.rdata = {m_ip, 16'h0000} & m_mie;
            csr_mscratch: r.rdata = m_mscratch;
            csr_mepc:     r.rdata = {m_mepc, 1'b0};
            csr_mcause:   r.rdata = {m_cause_int, 26'd0, m_cause_no};
            csr_medeleg, csr_mideleg, csr_mstatush, csr_mtval: r.rdata = 32'd0;
            csr_mvendorid, csr_marchid, csr_mimpid, csr_mconfigptr: r.rdonly = 1'b1;
            csr_mhartid: begin
                r.rdonly = 1'b1;
                r.rdata  = hart_id;
            end
            default:      r.exists = 1'b0;
        endcase
        return r;
    endfunction

    task automatic model_reset();
        m_mie_bit   = 1'b0;
        m_mpie      = 1'b0;
        m_mie       = 32'd0;
        m_mtvec     = '0;
        m_mscratch  = 32'd0;
        m_mepc      = '0;
        m_cause_int = 1'b0;
        m_cause_no  = 5'd0;
        m_ip        = '0;
        m_prev_mie  = 1'b0;
    endtask

    task automatic model_write(input logic [11:0] addr, input logic [31:0] wdata);
        case (addr)
            csr_mstatus: begin
                m_mpie    = wdata[7];
                m_mie_bit = wdata[3];
            end
            csr_mie:      m_mie = wdata;
            csr_mtvec:    m_mtvec = wdata[31:2];
            csr_mscratch: m_mscratch = wdata;
            csr_mepc:     m_mepc = wdata[31:1];
            csr_mcause: begin
                m_cause_int = wdata[31];
                m_cause_no  = wdata[4:0];
            end
            default: ;
        endcase
    endtask

    // Compare outputs with the model, then step the model over the edge.
    task automatic check_and_advance();
        csr_rsp_t    exp_rsp;
        exc_out_t    exp_exc;
        logic [31:0] masked;
        logic        pend;
        logic        found;
        logic [4:0]  irq_no;
        logic        old_mie;
        upd_e        kind;
        exp_rsp = model_rsp(csr_req.addr);
        masked  = {m_ip, 16'h0000} & m_mie;
        pend    = (masked != 32'd0) && m_mie_bit && m_prev_mie;
        found   = 1'b0;
        irq_no  = 5'd0;
        for (int i = 16; i < 32; i++) begin
            if (masked[i] && !found) begin
                irq_no = 5'(i);
                found  = 1'b1;
            end
        end
        // Return beats interrupt, interrupt beats trap, trap beats write.
        if (mret) begin
            kind = upd_ret;
        end else if (pend || trap.valid) begin
            kind = upd_enter;
        end else if (csr_req.we && exp_rsp.exists && !exp_rsp.rdonly) begin
            kind = upd_write;
        end else begin
            kind = upd_none;
        end
        exp_exc.take    = (kind == upd_enter);
        exp_exc.is_irq  = (kind == upd_enter) && pend;
        exp_exc.tvec    = m_mtvec;
        exp_exc.ret_epc = m_mepc;

        assert (csr_rsp === exp_rsp) else begin
            $display("mismatch csr_rsp exp %h got %h", exp_rsp, csr_rsp);
            test_errors++;
        end
        assert (exc === exp_exc) else begin
            $display("mismatch exc exp %h got %h", exp_exc, exc);
            test_errors++;
        end

        old_mie = m_mie_bit;
        case (kind)
            upd_ret: m_mie_bit = m_mpie;
            upd_enter: begin
                m_mpie    = m_mie_bit;
                m_mie_bit = 1'b0;
                if (pend) begin
                    m_mepc      = pc;
                    m_cause_int = 1'b1;
                    m_cause_no  = irq_no;
                end else begin
                    m_mepc      = trap.epc;
                    m_cause_int = 1'b0;
                    m_cause_no  = {1'b0, trap.cause};
                end
            end
            upd_write: model_write(csr_req.addr, csr_req.wdata);
            default: ;
        endcase
        m_ip       = irq;
        m_prev_mie = old_mie;
        test_cycles++;
        checks++;
    endtask

    task automatic run_cycle(input csr_req_t req, input trap_req_t tr, input logic mr,
                             input logic [31:16] ir);
        logic [31:0] r;
        @(negedge clk);
        r       = rand32();
        csr_req = req;
        trap    = tr;
        mret    = mr;
        pc      = r[31:1];
        irq     = ir;
        #(period / 2 - 10);
        check_and_advance();
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        model_reset();
    endtask

    task automatic finish_test(input string name);
        $display("test %-6s %5d cycles %3d errors", name, test_cycles, test_errors);
        total_errors += test_errors;
        n_tests++;
        test_cycles = 0;
        test_errors = 0;
    endtask

    task automatic test_read();
        for (int i = 0; i < 17; i++) begin
            run_cycle(make_req(1'b0, known_addr[i], rand32()), make_trap(1'b0), 1'b0, '0);
        end
        for (int i = 0; i < n_unknown; i++) begin
            run_cycle(make_req(1'b0, unknown_addr(rand32()), 32'd0), make_trap(1'b0),
                      1'b0, '0);
        end
        finish_test("read");
    endtask

    // Each write is read back in the next cycle.
    task automatic test_write();
        logic [11:0] a;
        for (int i = 0; i < n_write; i++) begin
            a = pick_addr(rand32());
            run_cycle(make_req(1'b1, a, rand32()), make_trap(1'b0), 1'b0, '0);
            run_cycle(make_req(1'b0, a, 32'd0), make_trap(1'b0), 1'b0, '0);
        end
        finish_test("write");
    endtask

    task automatic test_trap();
        for (int i = 0; i < n_trap; i++) begin
            run_cycle(make_req(1'b1, csr_mstatus, rand32()), make_trap(1'b0), 1'b0, '0);
            run_cycle(make_req(1'b0, pick_addr(rand32()), 32'd0), make_trap(1'b1), 1'b0, '0);
            run_cycle(make_req(1'b0, csr_mepc, 32'd0), make_trap(1'b0), 1'b0, '0);
            run_cycle(make_req(1'b0, csr_mcause, 32'd0), make_trap(1'b0), 1'b0, '0);
            run_cycle(make_req(1'b0, csr_mstatus, 32'd0), make_trap(1'b0), 1'b0, '0);
        end
        finish_test("trap");
    endtask

    // MIE is set most of the time so the two-cycle rule gets exercised.
    task automatic test_irq();
        logic [31:0] r;
        logic [31:0] s;
        for (int i = 0; i < n_irq; i++) begin
            run_cycle(make_req(1'b1, csr_mie, rand32()), make_trap(1'b0), 1'b0, '0);
            r    = rand32();
            r[3] = r[3] | r[5];
            s    = rand32();
            // Lines sampled here are pending while MIE is only one cycle old.
            run_cycle(make_req(1'b1, csr_mstatus, r), make_trap(1'b0), 1'b0, s[31:16]);
            for (int k = 0; k < 4; k++) begin
                r = rand32();
                run_cycle(make_req(1'b0, r[0] ? csr_mcause : csr_mstatus, 32'd0),
                          make_trap(r[1]), 1'b0, r[31:16]);
            end
        end
        finish_test("irq");
    endtask

    task automatic test_mret();
        logic [31:0] r;
        for (int i = 0; i < n_mret; i++) begin
            run_cycle(make_req(1'b1, csr_mstatus, rand32()), make_trap(1'b0), 1'b0, '0);
            run_cycle(make_req(1'b1, csr_mepc, rand32()), make_trap(1'b0), 1'b0, '0);
            r = rand32();
            run_cycle(make_req(1'b0, csr_mstatus, 32'd0), make_trap(r[0]), 1'b1, '0);
            run_cycle(make_req(1'b0, csr_mstatus, 32'd0), make_trap(1'b0), 1'b0, '0);
            run_cycle(make_req(1'b0, csr_mepc, 32'd0), make_trap(1'b0), 1'b0, '0);
        end
        finish_test("mret");
    endtask

    task automatic test_mixed();
        logic [31:0] r;
        logic [31:0] s;
        csr_req_t    q;
        for (int i = 0; i < n_mixed; i++) begin
            r = rand32();
            s = rand32();
            q = make_req(r[1:0] == 2'b00, pick_addr(s), rand32());
            // Frequent MIE enables keep interrupts reachable.
            if (r[12:11] == 2'b00) begin
                q.addr     = csr_mstatus;
                q.wdata[3] = 1'b1;
            end
            run_cycle(q, make_trap(r[4:2] == 3'b000), r[8:5] == 4'h0,
                      (r[10:9] == 2'b00) ? s[31:16] : 16'h0000);
        end
        finish_test("mixed");
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        csr_req      = '0;
        trap         = '0;
        mret         = 1'b0;
        pc           = '0;
        irq          = '0;
        lcg_state    = 32'h858c;
        test_cycles  = 0;
        test_errors  = 0;
        total_errors = 0;
        checks       = 0;
        n_tests      = 0;
        model_reset();
        apply_reset();
        test_read();
        test_write();
        test_trap();
        test_irq();
        test_mret();
        test_mixed();
        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, total_errors);
        if (total_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog sized from the planned cycle count.
    initial begin
        #((n_total + margin) * period);
        $display("Timeout after %0d cycles, tests did not complete", n_total + margin);
        $display("Something failed");
        $finish;
    end

endmodule

// File: vlog.f
rtl/mcsr_pkg.sv
rtl/csr_addr_decode.sv
rtl/irq_arbiter.sv
rtl/trap_ctrl.sv
rtl/csr_regs.sv
rtl/mcsr_unit.sv
dv/mcsr_sva.sv
dv/mcsr_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -j 0
TOP       := mcsr_tb
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Something failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
